//--- files.f
logic/corePkg.sv
logic/registerFile.sv
logic/fetchDecode.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/writebackStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
bench/mipsCoreBench.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f files.f --top-module mipsCoreBench -o mipsCoreBench

run: compile
	@out="$$(./obj_dir/mipsCoreBench)"; echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir

//--- bench/mipsCoreBench.sv
`timescale 1ns/1ps

module mipsCoreBench;

	localparam int programLen = 60;
	// self-loop sits right after the program
	localparam int loopIdx = programLen;
	localparam int resetCycles = 16;
	localparam int clkPeriod = 100;
	localparam int watchdogCycles = programLen * 8 + resetCycles;
	localparam int memWords = 64;

	logic clk;
	logic arstN;
	corePkg::word pc;
	corePkg::word instr;
	logic cyc;
	logic stb;
	logic we;
	corePkg::word adr;
	corePkg::byteSel sel;
	corePkg::word datW;
	corePkg::word datR;
	logic ack;
	logic retireValid;
	corePkg::word retirePc;
	logic retireWe;
	corePkg::regAddr retireReg;
	corePkg::word retireData;

	// ==============================
	// bench state
	// ==============================
	logic [31:0] lfsr;
	corePkg::word rom [memWords];
	corePkg::word slaveMem [memWords];
	corePkg::word modelMem [memWords];
	corePkg::word modelRegs [32];
	corePkg::word modelPc;
	corePkg::word modelNext;
	// one entry per bus cycle: we, sel, adr, datW
	logic [68:0] busLog [$];
	logic [68:0] busSnap;
	logic busBusy;
	int waitLeft;
	int errors;
	int checks;
	int testErrors;
	int retired;
	logic finished;

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	// combinational instruction rom, no-op outside the program
	assign instr = (pc[31:8] == '0) ? rom[pc[7:2]] : '0;

	mipsCore i_mipsCore (
		.clk,
		.arstN,
		.pc,
		.instr,
		.cyc,
		.stb,
		.we,
		.adr,
		.sel,
		.datW,
		.datR,
		.ack,
		.retireValid,
		.retirePc,
		.retireWe,
		.retireReg,
		.retireData
	);

	// ==============================
	// helpers
	// ==============================
	// galois lfsr, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// registers 1 to 7 only
	function automatic logic [4:0] pickReg();
		return 5'(1 + randBits(3) % 7);
	endfunction

	// mixes every address bit
	function automatic corePkg::word fillWord(input int idx);
		corePkg::word addr;
		addr = 32'(idx) << 2;
		return (addr * 32'h9e3779b1) ^ {addr[7:0], ~addr[7:0], addr[15:0]};
	endfunction

	function automatic corePkg::word rWord(input corePkg::opField fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {corePkg::opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic corePkg::word iWord(input corePkg::opField opc, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic corePkg::word jWord(input int idx);
		return {corePkg::opJ, 26'(idx)};
	endfunction

	task automatic checkValue(input corePkg::word got, input corePkg::word exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ==============================
	// random program
	// ==============================
	task automatic buildProgram();
		logic [3:0] kind;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
		int span;
		for (int i = 0; i < memWords; i++) begin
			rom[i] = '0;
		end
		for (int i = 0; i < programLen; i++) begin
			kind = 4'(randBits(4));
			rs = pickReg();
			rt = pickReg();
			rd = pickReg();
			imm = 16'(randBits(16));
			// forward targets never pass the final loop
			span = 1 + int'(randBits(2));
			if (span > loopIdx - 1 - i) begin
				span = loopIdx - 1 - i;
			end
			if (kind >= 4'd13 && span < 1) begin
				kind = 4'd6;
			end
			// loads and stores use r0 as base, inside the data area
			case (kind)
				4'd0: rom[i] = rWord(corePkg::fnAddu, rs, rt, rd);
				4'd1: rom[i] = rWord(corePkg::fnSubu, rs, rt, rd);
				4'd2: rom[i] = rWord(corePkg::fnAnd, rs, rt, rd);
				4'd3: rom[i] = rWord(corePkg::fnOr, rs, rt, rd);
				4'd4: rom[i] = rWord(corePkg::fnSlt, rs, rt, rd);
				4'd5: rom[i] = iWord(corePkg::opAddiu, rs, rt, imm);
				4'd6: rom[i] = iWord(corePkg::opOri, rs, rt, imm);
				4'd7: rom[i] = iWord(corePkg::opLui, 5'd0, rt, imm);
				4'd8: rom[i] = iWord(corePkg::opLw, 5'd0, rt, {8'h0, imm[7:2], 2'b00});
				4'd9: rom[i] = iWord(corePkg::opLb, 5'd0, rt, {8'h0, imm[7:0]});
				4'd10: rom[i] = iWord(corePkg::opLbu, 5'd0, rt, {8'h0, imm[7:0]});
				4'd11: rom[i] = iWord(corePkg::opSw, 5'd0, rt, {8'h0, imm[7:2], 2'b00});
				4'd12: rom[i] = iWord(corePkg::opSb, 5'd0, rt, {8'h0, imm[7:0]});
				4'd13, 4'd14: begin
					// same register now and then, so some branches always go one way
					if (randBits(1) == 32'd1) begin
						rt = rs;
					end
					rom[i] = iWord((kind == 4'd13) ? corePkg::opBeq : corePkg::opBne,
						rs, rt, 16'(span));
				end
				default: rom[i] = jWord(i + 1 + span);
			endcase
		end
		rom[loopIdx] = jWord(loopIdx);
		rom[loopIdx + 1] = '0;
	endtask

	// ==============================
	// reference model
	// ==============================
	task automatic retireStep();
		corePkg::word inst;
		corePkg::opField opc;
		corePkg::opField fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] dest;
		corePkg::word a;
		corePkg::word b;
		corePkg::word se;
		corePkg::word addr;
		corePkg::word oldWord;
		corePkg::word result;
		corePkg::word target;
		logic [7:0] lane;
		logic wr;
		logic isMem;
		logic isStore;
		logic [68:0] xfer;
		inst = rom[modelPc[7:2]];
		opc = inst[31:26];
		fn = inst[5:0];
		rs = inst[25:21];
		rt = inst[20:16];
		rd = inst[15:11];
		a = modelRegs[rs];
		b = modelRegs[rt];
		se = {{16{inst[15]}}, inst[15:0]};
		addr = a + se;
		oldWord = modelMem[addr[7:2]];
		lane = oldWord[8 * addr[1:0] +: 8];
		result = '0;
		wr = 1'b0;
		dest = rt;
		isMem = 1'b0;
		isStore = 1'b0;
		// delay slot: the instruction after this one is already queued
		target = modelNext + 32'd4;
		case (opc)
			corePkg::opSpecial: begin
				dest = rd;
				wr = 1'b1;
				case (fn)
					corePkg::fnAddu: result = a + b;
					corePkg::fnSubu: result = a - b;
					corePkg::fnAnd: result = a & b;
					corePkg::fnOr: result = a | b;
					corePkg::fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			corePkg::opAddiu: begin
				wr = 1'b1;
				result = a + se;
			end
			corePkg::opOri: begin
				wr = 1'b1;
				result = a | {16'h0, inst[15:0]};
			end
			corePkg::opLui: begin
				wr = 1'b1;
				result = {inst[15:0], 16'h0};
			end
			corePkg::opLw: begin
				wr = 1'b1;
				isMem = 1'b1;
				result = oldWord;
			end
			corePkg::opLb: begin
				wr = 1'b1;
				isMem = 1'b1;
				result = {{24{lane[7]}}, lane};
			end
			corePkg::opLbu: begin
				wr = 1'b1;
				isMem = 1'b1;
				result = {24'h0, lane};
			end
			corePkg::opSw, corePkg::opSb: begin
				isMem = 1'b1;
				isStore = 1'b1;
			end
			corePkg::opBeq: begin
				if (a == b) begin
					target = modelPc + 32'd4 + (se << 2);
				end
			end
			corePkg::opBne: begin
				if (a != b) begin
					target = modelPc + 32'd4 + (se << 2);
				end
			end
			corePkg::opJ: target = {modelPc[31:28], inst[25:0], 2'b00};
			default: wr = 1'b0;
		endcase

		checkValue(retirePc, modelPc, "retire pc");
		checkValue(32'(retireWe), 32'(wr), "retire we");
		if (wr) begin
			checkValue(32'(retireReg), 32'(dest), "retire reg");
			checkValue(retireData, result, "retire data");
		end

		// bus cycle seen by the slave for this access
		if (isMem && busLog.size() == 0) begin
			errors++;
			$display("load or store at pc %h retired without a bus cycle", modelPc);
		end else if (isMem) begin
			xfer = busLog.pop_front();
			checkValue(32'(xfer[68]), 32'(isStore), "bus we");
			checkValue({xfer[63:34], 2'b00}, {addr[31:2], 2'b00}, "bus adr");
			if (opc == corePkg::opSw) begin
				checkValue(32'(xfer[67:64]), 32'hf, "bus sel for sw");
				checkValue(xfer[31:0], b, "bus datW for sw");
				modelMem[addr[7:2]] = b;
			end else if (opc == corePkg::opSb) begin
				checkValue(32'(xfer[67:64]), 32'(4'b0001 << addr[1:0]), "bus sel for sb");
				checkValue(xfer[31:0], {4{b[7:0]}}, "bus datW for sb");
				modelMem[addr[7:2]][8 * addr[1:0] +: 8] = b[7:0];
			end
		end

		if (wr && dest != 5'd0) begin
			modelRegs[dest] = result;
		end
		if (modelPc == 32'(loopIdx * 4)) begin
			finished = 1'b1;
		end
		modelPc = modelNext;
		modelNext = target;
		retired++;
	endtask

	// ==============================
	// wishbone slave
	// ==============================
	task automatic serveBus();
		logic [68:0] cur;
		int idx;
		cur = {we, sel, adr, datW};
		if (cyc && stb) begin
			if (!busBusy) begin
				// new cycle, pick its wait states
				busBusy = 1'b1;
				busSnap = cur;
				waitLeft = int'(randBits(2));
				busLog.push_back(cur);
			end else begin
				checkValue(32'(cur[68:64]), 32'(busSnap[68:64]), "bus we and sel held");
				checkValue(cur[63:32], busSnap[63:32], "bus adr held");
				checkValue(cur[31:0], busSnap[31:0], "bus datW held");
			end
			if (waitLeft == 0) begin
				idx = int'(adr[7:2]);
				ack <= 1'b1;
				datR <= slaveMem[idx];
				if (we) begin
					for (int k = 0; k < 4; k++) begin
						if (sel[k]) begin
							slaveMem[idx][8 * k +: 8] = datW[8 * k +: 8];
						end
					end
				end
				busBusy = 1'b0;
			end else begin
				waitLeft--;
				ack <= 1'b0;
			end
		end else begin
			ack <= 1'b0;
		end
	endtask

	// outputs are stable at the falling edge, inputs change here too
	always @(negedge clk) begin
		if (retireValid && !finished) begin
			retireStep();
		end
		serveBus();
	end

	// ==============================
	// test sequence
	// ==============================
	initial begin
		arstN = 1'b0;
		ack = 1'b0;
		datR = '0;
		lfsr = 32'hd89f;
		errors = 0;
		checks = 0;
		retired = 0;
		finished = 1'b0;
		busBusy = 1'b0;
		waitLeft = 0;
		buildProgram();
		for (int i = 0; i < memWords; i++) begin
			slaveMem[i] = fillWord(i);
			modelMem[i] = fillWord(i);
		end
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		modelPc = '0;
		modelNext = 32'd4;

		// quiet outputs while in reset
		testErrors = errors;
		repeat (resetCycles - 1) @(negedge clk);
		checkValue(32'(retireValid), 32'd0, "retireValid in reset");
		checkValue(32'(cyc), 32'd0, "cyc in reset");
		checkValue(32'(stb), 32'd0, "stb in reset");
		checkValue(pc, 32'd0, "pc in reset");
		@(negedge clk);
		arstN = 1'b1;
		$display("test reset: %0d errors", errors - testErrors);

		// run until the self-loop jump retires
		testErrors = errors;
		while (!finished) begin
			@(negedge clk);
		end
		$display("test program: %0d retired, %0d errors", retired, errors - testErrors);

		testErrors = errors;
		for (int i = 0; i < memWords; i++) begin
			checkValue(slaveMem[i], modelMem[i], $sformatf("data memory word %0d", i));
		end
		if (busLog.size() != 0) begin
			errors++;
			$display("%0d bus cycles had no matching load or store", busLog.size());
		end
		$display("test memory: %0d errors", errors - testErrors);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// bound on the whole run
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired after %0d cycles before the final loop", watchdogCycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic arstN,
	// instruction fetch
	output corePkg::word pc,
	input corePkg::word instr,
	// wishbone data master
	output logic cyc,
	output logic stb,
	output logic we,
	output corePkg::word adr,
	output corePkg::byteSel sel,
	output corePkg::word datW,
	input corePkg::word datR,
	input logic ack,
	// retire port
	output logic retireValid,
	output corePkg::word retirePc,
	output logic retireWe,
	output corePkg::regAddr retireReg,
	output corePkg::word retireData
);

	// ==============================
	// pipeline control
	// ==============================
	logic stallFront;
	logic busWait;
	corePkg::fwdSel fwdA;
	corePkg::fwdSel fwdB;
	logic branchFwdA;
	logic branchFwdB;

	// decode
	corePkg::regAddr rsD;
	corePkg::regAddr rtD;
	corePkg::regAddr rdD;
	logic isBranchD;
	logic validD;
	corePkg::word srcA;
	corePkg::word srcB;
	corePkg::word imm;
	corePkg::aluOp op;
	logic useImm;
	logic regWr;
	logic isLoad;
	logic isStore;
	logic loadByte;
	logic loadSigned;
	logic storeByte;
	corePkg::word pcD;

	// execute
	corePkg::regAddr rsE;
	corePkg::regAddr rtE;
	corePkg::regAddr destE;
	logic regWrE;
	logic isLoadE;
	logic validE;
	corePkg::word aluResult;
	corePkg::word storeData;
	logic isStoreE;
	logic loadByteE;
	logic loadSignedE;
	logic storeByteE;
	corePkg::word pcE;

	// memory
	corePkg::word memResult;
	corePkg::regAddr destM;
	logic regWrM;
	logic isLoadM;
	logic validM;
	corePkg::word loadWord;
	logic loadByteM;
	logic loadSignedM;
	corePkg::word pcM;

	// writeback
	corePkg::regAddr destW;
	logic regWrW;
	corePkg::word wbData;

	// ==============================
	// stages
	// ==============================
	fetchDecode i_fetchDecode (
		.clk,
		.arstN,
		.stallFront,
		.busWait,
		.instr,
		.pc,
		.branchFwdA,
		.branchFwdB,
		.memResult,
		.wbWe(regWrW),
		.wbReg(destW),
		.wbData,
		.rsD,
		.rtD,
		.isBranchD,
		.validD,
		.srcA,
		.srcB,
		.imm,
		.rdD,
		.op,
		.useImm,
		.regWr,
		.isLoad,
		.isStore,
		.loadByte,
		.loadSigned,
		.storeByte,
		.pcD
	);

	hazardUnit i_hazardUnit (
		.rsD,
		.rtD,
		.isBranchD,
		.rsE,
		.rtE,
		.destE,
		.regWrE,
		.isLoadE,
		.destM,
		.regWrM,
		.isLoadM,
		.destW,
		.regWrW,
		.stallFront,
		.fwdA,
		.fwdB,
		.branchFwdA,
		.branchFwdB
	);

	executeStage i_executeStage (
		.clk,
		.arstN,
		.stallFront,
		.busWait,
		.validD,
		.srcA,
		.srcB,
		.imm,
		.rsD,
		.rtD,
		.rdD,
		.op,
		.useImm,
		.regWr,
		.isLoad,
		.isStore,
		.loadByte,
		.loadSigned,
		.storeByte,
		.pcD,
		.fwdA,
		.fwdB,
		.memResult,
		.wbData,
		.rsE,
		.rtE,
		.destE,
		.regWrE,
		.isLoadE,
		.validE,
		.aluResult,
		.storeData,
		.isStoreE,
		.loadByteE,
		.loadSignedE,
		.storeByteE,
		.pcE
	);

	memoryStage i_memoryStage (
		.clk,
		.arstN,
		.validE,
		.aluResult,
		.storeData,
		.destE,
		.regWrE,
		.isLoadE,
		.isStoreE,
		.loadByteE,
		.loadSignedE,
		.storeByteE,
		.pcE,
		.cyc,
		.stb,
		.we,
		.adr,
		.sel,
		.datW,
		.datR,
		.ack,
		.busWait,
		.memResult,
		.destM,
		.regWrM,
		.isLoadM,
		.validM,
		.loadWord,
		.loadByteM,
		.loadSignedM,
		.pcM
	);

	writebackStage i_writebackStage (
		.clk,
		.arstN,
		.busWait,
		.validM,
		.memResult,
		.loadWord,
		.destM,
		.regWrM,
		.isLoadM,
		.loadByteM,
		.loadSignedM,
		.pcM,
		.destW,
		.regWrW,
		.wbData,
		.retireValid,
		.retirePc,
		.retireWe,
		.retireReg,
		.retireData
	);

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	// decode
	input corePkg::regAddr rsD,
	input corePkg::regAddr rtD,
	input logic isBranchD,
	// execute
	input corePkg::regAddr rsE,
	input corePkg::regAddr rtE,
	input corePkg::regAddr destE,
	input logic regWrE,
	input logic isLoadE,
	// memory
	input corePkg::regAddr destM,
	input logic regWrM,
	input logic isLoadM,
	// writeback
	input corePkg::regAddr destW,
	input logic regWrW,
	// stalls and forward selects
	output logic stallFront,
	output corePkg::fwdSel fwdA,
	output corePkg::fwdSel fwdB,
	output logic branchFwdA,
	output logic branchFwdB
);

	logic useE;
	logic useM;
	logic loadUse;
	logic branchWaitE;
	logic branchWaitM;

	// r0 never counts as a producer
	function automatic logic hit(
		input corePkg::regAddr src,
		input corePkg::regAddr dst,
		input logic wr
	);
		return wr && (dst != '0) && (src == dst);
	endfunction

	// ==============================
	// stalls
	// ==============================
	// decode reads something execute or memory will write
	assign useE = hit(rsD, destE, regWrE) | hit(rtD, destE, regWrE);
	assign useM = hit(rsD, destM, regWrM) | hit(rtD, destM, regWrM);

	// load data only exists after memory
	assign loadUse = isLoadE & useE;
	// branch compares in decode, so execute results are too late
	assign branchWaitE = isBranchD & useE;
	// a load in memory has no forward path to decode
	assign branchWaitM = isBranchD & isLoadM & useM;

	assign stallFront = loadUse | branchWaitE | branchWaitM;

	// ==============================
	// forward selects
	// ==============================
	// alu result in memory into the branch compare
	assign branchFwdA = hit(rsD, destM, regWrM) & ~isLoadM;
	assign branchFwdB = hit(rtD, destM, regWrM) & ~isLoadM;

	// memory is newer than writeback
	always_comb begin
		fwdA = corePkg::fwdNone;
		fwdB = corePkg::fwdNone;
		if (hit(rsE, destM, regWrM)) begin
			fwdA = corePkg::fwdMem;
		end else if (hit(rsE, destW, regWrW)) begin
			fwdA = corePkg::fwdWb;
		end
		if (hit(rtE, destM, regWrM)) begin
			fwdB = corePkg::fwdMem;
		end else if (hit(rtE, destW, regWrW)) begin
			fwdB = corePkg::fwdWb;
		end
	end

endmodule

//--- logic/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
	input logic clk,
	input logic arstN,
	input logic busWait,
	// from memory
	input logic validM,
	input corePkg::word memResult,
	input corePkg::word loadWord,
	input corePkg::regAddr destM,
	input logic regWrM,
	input logic isLoadM,
	input logic loadByteM,
	input logic loadSignedM,
	input corePkg::word pcM,
	// register write and forward source
	output corePkg::regAddr destW,
	output logic regWrW,
	output corePkg::word wbData,
	// retire port
	output logic retireValid,
	output corePkg::word retirePc,
	output logic retireWe,
	output corePkg::regAddr retireReg,
	output corePkg::word retireData
);

	logic validW;
	logic heldW;
	logic isLoadW;
	logic loadByteW;
	logic loadSignedW;
	corePkg::word aluResultW;
	corePkg::word loadWordW;
	corePkg::word pcW;
	logic [7:0] loadLane;
	corePkg::word loadValue;

	// ==============================
	// memory to writeback register
	// ==============================
	// held under a bus wait so execute can keep forwarding from here
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validW <= 1'b0;
			heldW <= 1'b0;
			regWrW <= 1'b0;
			isLoadW <= 1'b0;
			loadByteW <= 1'b0;
			loadSignedW <= 1'b0;
			destW <= '0;
		end else begin
			// marks an instruction that has already retired
			heldW <= busWait;
			if (!busWait) begin
				validW <= validM;
				regWrW <= regWrM;
				isLoadW <= isLoadM;
				loadByteW <= loadByteM;
				loadSignedW <= loadSignedM;
				destW <= destM;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busWait) begin
			aluResultW <= memResult;
			loadWordW <= loadWord;
			pcW <= pcM;
		end
	end

	// ==============================
	// load extraction
	// ==============================
	// lane 0 is the lowest address
	assign loadLane = loadWordW[8 * aluResultW[1:0] +: 8];

	always_comb begin
		if (!loadByteW) begin
			loadValue = loadWordW;
		end else if (loadSignedW) begin
			loadValue = {{24{loadLane[7]}}, loadLane};
		end else begin
			loadValue = {24'h0, loadLane};
		end
	end

	assign wbData = isLoadW ? loadValue : aluResultW;

	// retire once, even if held behind a slow bus cycle
	assign retireValid = validW & ~heldW;
	assign retirePc = pcW;
	assign retireWe = regWrW;
	assign retireReg = destW;
	assign retireData = wbData;

endmodule

//--- logic/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
	input logic clk,
	input logic arstN,
	// from execute
	input logic validE,
	input corePkg::word aluResult,
	input corePkg::word storeData,
	input corePkg::regAddr destE,
	input logic regWrE,
	input logic isLoadE,
	input logic isStoreE,
	input logic loadByteE,
	input logic loadSignedE,
	input logic storeByteE,
	input corePkg::word pcE,
	// wishbone data master
	output logic cyc,
	output logic stb,
	output logic we,
	output corePkg::word adr,
	output corePkg::byteSel sel,
	output corePkg::word datW,
	input corePkg::word datR,
	input logic ack,
	// pipeline
	output logic busWait,
	output corePkg::word memResult,
	output corePkg::regAddr destM,
	output logic regWrM,
	output logic isLoadM,
	// toward writeback
	output logic validM,
	output corePkg::word loadWord,
	output logic loadByteM,
	output logic loadSignedM,
	output corePkg::word pcM
);

	logic isStoreM;
	logic storeByteM;
	corePkg::word storeDataM;
	corePkg::byteSel laneSel;

	// ==============================
	// execute to memory register
	// ==============================
	// held while the bus cycle is open
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validM <= 1'b0;
			regWrM <= 1'b0;
			isLoadM <= 1'b0;
			isStoreM <= 1'b0;
			loadByteM <= 1'b0;
			loadSignedM <= 1'b0;
			storeByteM <= 1'b0;
			destM <= '0;
		end else if (!busWait) begin
			validM <= validE;
			regWrM <= regWrE;
			isLoadM <= isLoadE;
			isStoreM <= isStoreE;
			loadByteM <= loadByteE;
			loadSignedM <= loadSignedE;
			storeByteM <= storeByteE;
			destM <= destE;
		end
	end

	always_ff @(posedge clk) begin
		if (!busWait) begin
			memResult <= aluResult;
			storeDataM <= storeData;
			pcM <= pcE;
		end
	end

	// ==============================
	// wishbone classic master
	// ==============================
	// one transfer per load or store, ended by the first ack
	assign cyc = isLoadM | isStoreM;
	assign stb = cyc;
	assign we = isStoreM;
	assign adr = {memResult[31:2], 2'b00};

	// byte accesses enable just the addressed lane
	assign laneSel = 4'b0001 << memResult[1:0];
	assign sel = (loadByteM | storeByteM) ? laneSel : 4'b1111;

	// sb copies the byte to every lane
	assign datW = storeByteM ? {4{storeDataM[7:0]}} : storeDataM;

	// freeze everything until the slave answers
	assign busWait = cyc & ~ack;

	// read data is sampled by writeback in the ack cycle
	assign loadWord = datR;

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic arstN,
	input logic stallFront,
	input logic busWait,
	// decoded instruction
	input logic validD,
	input corePkg::word srcA,
	input corePkg::word srcB,
	input corePkg::word imm,
	input corePkg::regAddr rsD,
	input corePkg::regAddr rtD,
	input corePkg::regAddr rdD,
	input corePkg::aluOp op,
	input logic useImm,
	input logic regWr,
	input logic isLoad,
	input logic isStore,
	input logic loadByte,
	input logic loadSigned,
	input logic storeByte,
	input corePkg::word pcD,
	// forwarding
	input corePkg::fwdSel fwdA,
	input corePkg::fwdSel fwdB,
	input corePkg::word memResult,
	input corePkg::word wbData,
	// toward hazard unit
	output corePkg::regAddr rsE,
	output corePkg::regAddr rtE,
	output corePkg::regAddr destE,
	output logic regWrE,
	output logic isLoadE,
	// toward memory
	output logic validE,
	output corePkg::word aluResult,
	output corePkg::word storeData,
	output logic isStoreE,
	output logic loadByteE,
	output logic loadSignedE,
	output logic storeByteE,
	output corePkg::word pcE
);

	corePkg::word srcAE;
	corePkg::word srcBE;
	corePkg::word immE;
	corePkg::regAddr rdE;
	corePkg::aluOp opE;
	logic useImmE;
	corePkg::word opA;
	corePkg::word aluB;

	// ==============================
	// decode to execute register
	// ==============================
	// control part, cleared to a bubble on a front stall
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validE <= 1'b0;
			regWrE <= 1'b0;
			isLoadE <= 1'b0;
			isStoreE <= 1'b0;
			loadByteE <= 1'b0;
			loadSignedE <= 1'b0;
			storeByteE <= 1'b0;
			useImmE <= 1'b0;
			rsE <= '0;
			rtE <= '0;
			rdE <= '0;
		end else if (!busWait) begin
			if (stallFront) begin
				validE <= 1'b0;
				regWrE <= 1'b0;
				isLoadE <= 1'b0;
				isStoreE <= 1'b0;
			end else begin
				validE <= validD;
				regWrE <= regWr;
				isLoadE <= isLoad;
				isStoreE <= isStore;
				loadByteE <= loadByte;
				loadSignedE <= loadSigned;
				storeByteE <= storeByte;
				useImmE <= useImm;
				rsE <= rsD;
				rtE <= rtD;
				rdE <= rdD;
			end
		end
	end

	// operands and pc
	always_ff @(posedge clk) begin
		if (!busWait && !stallFront) begin
			srcAE <= srcA;
			srcBE <= srcB;
			immE <= imm;
			opE <= op;
			pcE <= pcD;
		end
	end

	// ==============================
	// operand forwarding
	// ==============================
	function automatic corePkg::word pickOperand(
		input corePkg::fwdSel sel,
		input corePkg::word regVal,
		input corePkg::word memVal,
		input corePkg::word wbVal
	);
		case (sel)
			corePkg::fwdMem: return memVal;
			corePkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, srcAE, memResult, wbData);
	// rt value doubles as store data
	assign storeData = pickOperand(fwdB, srcBE, memResult, wbData);
	assign aluB = useImmE ? immE : storeData;

	// i-type writes rt, r-type writes rd
	assign destE = useImmE ? rtE : rdE;

	// ==============================
	// alu
	// ==============================
	always_comb begin
		case (opE)
			corePkg::aluAdd: aluResult = opA + aluB;
			corePkg::aluSub: aluResult = opA - aluB;
			corePkg::aluAnd: aluResult = opA & aluB;
			corePkg::aluOr: aluResult = opA | aluB;
			corePkg::aluSlt: aluResult = {31'b0, $signed(opA) < $signed(aluB)};
			corePkg::aluLui: aluResult = {aluB[15:0], 16'h0};
			default: aluResult = '0;
		endcase
	end

endmodule

//--- logic/fetchDecode.sv
`timescale 1ns/1ps

module fetchDecode (
	input logic clk,
	input logic arstN,
	input logic stallFront,
	input logic busWait,
	// instruction fetch
	input corePkg::word instr,
	output corePkg::word pc,
	// branch operands from memory stage
	input logic branchFwdA,
	input logic branchFwdB,
	input corePkg::word memResult,
	// register write from writeback
	input logic wbWe,
	input corePkg::regAddr wbReg,
	input corePkg::word wbData,
	// toward hazard unit
	output corePkg::regAddr rsD,
	output corePkg::regAddr rtD,
	output logic isBranchD,
	// decoded instruction toward execute
	output logic validD,
	output corePkg::word srcA,
	output corePkg::word srcB,
	output corePkg::word imm,
	output corePkg::regAddr rdD,
	output corePkg::aluOp op,
	output logic useImm,
	output logic regWr,
	output logic isLoad,
	output logic isStore,
	output logic loadByte,
	output logic loadSigned,
	output logic storeByte,
	output corePkg::word pcD
);

	logic frontEn;
	corePkg::word instrD;
	corePkg::opField opcode;
	corePkg::opField funct;
	logic isJump;
	logic isBeq;
	logic takeBranch;
	corePkg::word cmpA;
	corePkg::word cmpB;
	corePkg::word pcPlus4D;
	corePkg::word branchTarget;
	corePkg::word jumpTarget;
	corePkg::word nextPc;

	// pc and fetch register move together
	assign frontEn = ~busWait & ~stallFront;

	// ==============================
	// fetch
	// ==============================
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= corePkg::resetPc;
		end else if (frontEn) begin
			pc <= nextPc;
		end
	end

	// fetch to decode, a bubble until the first fetch lands
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validD <= 1'b0;
			instrD <= '0;
			pcD <= '0;
		end else if (frontEn) begin
			validD <= 1'b1;
			instrD <= instr;
			pcD <= pc;
		end
	end

	// ==============================
	// decode
	// ==============================
	assign opcode = instrD[31:26];
	assign funct = instrD[5:0];
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];

	// ori zero extends, all others sign extend
	assign imm = (opcode == corePkg::opOri) ? {16'h0, instrD[15:0]} :
		{{16{instrD[15]}}, instrD[15:0]};

	// unknown encodings fall out with no control set
	always_comb begin
		op = corePkg::aluAdd;
		useImm = 1'b0;
		regWr = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		loadByte = 1'b0;
		loadSigned = 1'b0;
		storeByte = 1'b0;
		isBranchD = 1'b0;
		isBeq = 1'b0;
		isJump = 1'b0;
		if (validD) begin
			case (opcode)
				corePkg::opSpecial: begin
					regWr = 1'b1;
					case (funct)
						corePkg::fnAddu: op = corePkg::aluAdd;
						corePkg::fnSubu: op = corePkg::aluSub;
						corePkg::fnAnd: op = corePkg::aluAnd;
						corePkg::fnOr: op = corePkg::aluOr;
						corePkg::fnSlt: op = corePkg::aluSlt;
						default: regWr = 1'b0;
					endcase
				end
				corePkg::opAddiu: begin
					useImm = 1'b1;
					regWr = 1'b1;
				end
				corePkg::opOri: begin
					op = corePkg::aluOr;
					useImm = 1'b1;
					regWr = 1'b1;
				end
				corePkg::opLui: begin
					op = corePkg::aluLui;
					useImm = 1'b1;
					regWr = 1'b1;
				end
				corePkg::opLw: begin
					useImm = 1'b1;
					regWr = 1'b1;
					isLoad = 1'b1;
				end
				corePkg::opLb: begin
					useImm = 1'b1;
					regWr = 1'b1;
					isLoad = 1'b1;
					loadByte = 1'b1;
					loadSigned = 1'b1;
				end
				corePkg::opLbu: begin
					useImm = 1'b1;
					regWr = 1'b1;
					isLoad = 1'b1;
					loadByte = 1'b1;
				end
				corePkg::opSw: begin
					useImm = 1'b1;
					isStore = 1'b1;
				end
				corePkg::opSb: begin
					useImm = 1'b1;
					isStore = 1'b1;
					storeByte = 1'b1;
				end
				corePkg::opBeq: begin
					isBranchD = 1'b1;
					isBeq = 1'b1;
				end
				corePkg::opBne: isBranchD = 1'b1;
				corePkg::opJ: isJump = 1'b1;
				default: regWr = 1'b0;
			endcase
		end
	end

	registerFile i_registerFile (
		.clk,
		.arstN,
		.readA(rsD),
		.readB(rtD),
		.dataA(srcA),
		.dataB(srcB),
		.writeEn(wbWe),
		.writeReg(wbReg),
		.writeData(wbData)
	);

	// ==============================
	// branch resolution
	// ==============================
	// memory stage alu result may be newer than the register file
	assign cmpA = branchFwdA ? memResult : srcA;
	assign cmpB = branchFwdB ? memResult : srcB;
	assign takeBranch = isBranchD & ((cmpA == cmpB) == isBeq);

	// targets are relative to the delay slot
	assign pcPlus4D = pcD + corePkg::pcStep;
	assign branchTarget = pcPlus4D + {imm[29:0], 2'b00};
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// pc already points at the delay slot here
	always_comb begin
		if (isJump) begin
			nextPc = jumpTarget;
		end else if (takeBranch) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pc + corePkg::pcStep;
		end
	end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic arstN,
	input corePkg::regAddr readA,
	input corePkg::regAddr readB,
	output corePkg::word dataA,
	output corePkg::word dataB,
	input logic writeEn,
	input corePkg::regAddr writeReg,
	input corePkg::word writeData
);

	corePkg::word regs [corePkg::regCount];

	// r0 is never stored
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < corePkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeReg != '0) begin
			regs[writeReg] <= writeData;
		end
	end

	// write-first, so decode sees the value writeback is storing this cycle
	function automatic corePkg::word readPort(input corePkg::regAddr addr);
		if (addr == '0) begin
			return '0;
		end
		if (writeEn && addr == writeReg) begin
			return writeData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		dataA = readPort(readA);
		dataB = readPort(readB);
	end

endmodule

//--- logic/corePkg.sv
package corePkg;

	// ==============================
	// widths and basic types
	// ==============================
	localparam int wordBits = 32;
	localparam int regBits = 5;
	localparam int regCount = 1 << regBits;

	// data or address
	typedef logic [wordBits-1:0] word;
	// register number
	typedef logic [regBits-1:0] regAddr;
	typedef logic [2:0] aluOp;
	// one bit per byte lane on the data bus
	typedef logic [3:0] byteSel;
	// operand source into execute
	typedef logic [1:0] fwdSel;
	// opcode and funct fields share a width
	typedef logic [5:0] opField;

	// fetch starts here after reset
	localparam word resetPc = '0;
	localparam word pcStep = 32'd4;

	// ==============================
	// instruction encodings
	// ==============================
	localparam opField opSpecial = 6'h00;
	localparam opField opJ = 6'h02;
	localparam opField opBeq = 6'h04;
	localparam opField opBne = 6'h05;
	localparam opField opAddiu = 6'h09;
	localparam opField opOri = 6'h0d;
	localparam opField opLui = 6'h0f;
	localparam opField opLb = 6'h20;
	localparam opField opLw = 6'h23;
	localparam opField opLbu = 6'h24;
	localparam opField opSb = 6'h28;
	localparam opField opSw = 6'h2b;

	// funct field under opSpecial
	localparam opField fnAddu = 6'h21;
	localparam opField fnSubu = 6'h23;
	localparam opField fnAnd = 6'h24;
	localparam opField fnOr = 6'h25;
	localparam opField fnSlt = 6'h2a;

	// alu operations
	localparam aluOp aluAdd = 3'd0;
	localparam aluOp aluSub = 3'd1;
	localparam aluOp aluAnd = 3'd2;
	localparam aluOp aluOr = 3'd3;
	localparam aluOp aluSlt = 3'd4;
	localparam aluOp aluLui = 3'd5;

	// forward selects, newest producer wins
	localparam fwdSel fwdNone = 2'd0;
	localparam fwdSel fwdMem = 2'd1;
	localparam fwdSel fwdWb = 2'd2;

endpackage
